// File: rtl/stbuf_cfg_pkg.sv
package stbuf_cfg_pkg;

   // ----------------------------------------
   // buffer geometry
   // ----------------------------------------
   localparam int DEPTH       = 8;
   localparam int PTR_W       = 3;
   localparam int COUNT_W     = 4;   // holds 0..DEPTH
   localparam int RESOLVE_LAG = 2;   // write to commit/flush decision

   // ----------------------------------------
   // data path widths
   // ----------------------------------------
   localparam int ADDR_BITS  = 16;
   localparam int DATA_WIDTH = 32;
   localparam int BYTE_WIDTH = 4;
   localparam int LANE_BITS  = $clog2(BYTE_WIDTH);   // byte offset within a word

   typedef logic [ADDR_BITS-1:0]           addr_t;
   typedef logic [ADDR_BITS-LANE_BITS-1:0] word_addr_t;
   typedef logic [DATA_WIDTH-1:0]          data_t;
   typedef logic [BYTE_WIDTH-1:0]          byteen_t;
   typedef logic [PTR_W-1:0]               ptr_t;

endpackage

// File: rtl/stbuf_op_pkg.sv
package stbuf_op_pkg;

   // access size of a store
   typedef enum logic [1:0] {
      SIZE_BYTE  = 2'd0,
      SIZE_HALF  = 2'd1,
      SIZE_WORD  = 2'd2,
      SIZE_DWORD = 2'd3
   } size_t;

   // lanes over two words, before the shift by addr[1:0]
   localparam logic [7:0] LANE_MASK_BYTE  = 8'b0000_0001;
   localparam logic [7:0] LANE_MASK_HALF  = 8'b0000_0011;
   localparam logic [7:0] LANE_MASK_WORD  = 8'b0000_1111;
   localparam logic [7:0] LANE_MASK_DWORD = 8'b1111_1111;

endpackage

// File: rtl/stbuf_entries.sv
module stbuf_entries (
   input  logic                                                  clk,
   input  logic                                                  rst_n,
   input  logic                                                  store_vld,
   input  stbuf_cfg_pkg::addr_t                                  store_addr,
   input  stbuf_op_pkg::size_t                                   store_size,
   input  stbuf_cfg_pkg::data_t                                  store_data_lo,
   input  stbuf_cfg_pkg::data_t                                  store_data_hi,
   input  logic                                                  resolve_vld,
   input  logic                                                  resolve_commit,
   input  logic                                                  drain_ack,
   output logic                                                  drain_req,
   output stbuf_cfg_pkg::addr_t                                  drain_addr,
   output stbuf_cfg_pkg::byteen_t                                drain_byteen,
   output stbuf_cfg_pkg::data_t                                  drain_data,
   output logic                                                  stbuf_full,
   output logic                                                  stbuf_empty,
   output logic [stbuf_cfg_pkg::DEPTH-1:0]                       ent_vld,
   output logic [stbuf_cfg_pkg::DEPTH-1:0]                       ent_flushed,
   output stbuf_cfg_pkg::word_addr_t [stbuf_cfg_pkg::DEPTH-1:0] ent_word,
   output stbuf_cfg_pkg::byteen_t [stbuf_cfg_pkg::DEPTH-1:0]    ent_byteen,
   output stbuf_cfg_pkg::data_t [stbuf_cfg_pkg::DEPTH-1:0]      ent_data,
   output stbuf_cfg_pkg::ptr_t                                   wr_ptr,
   output logic                                                  wr_vld,
   output logic                                                  wr_dual,
   output stbuf_cfg_pkg::word_addr_t                             wr_word_lo,
   output stbuf_cfg_pkg::word_addr_t                             wr_word_hi,
   output stbuf_cfg_pkg::byteen_t                                wr_byteen_lo,
   output stbuf_cfg_pkg::byteen_t                                wr_byteen_hi
);

   localparam int LAG = stbuf_cfg_pkg::RESOLVE_LAG;

   logic [7:0]                          size_mask;
   logic [7:0]                          lane_ext;
   stbuf_cfg_pkg::ptr_t                 wr_ptr_p1;
   stbuf_cfg_pkg::ptr_t                 rd_ptr;
   stbuf_cfg_pkg::ptr_t                 res_ptr [LAG];
   logic                                res_dual [LAG];
   stbuf_cfg_pkg::ptr_t                 res_ptr_p1;
   logic [stbuf_cfg_pkg::DEPTH-1:0]     ent_drain;   // committed, may go to memory
   logic                                pop;
   logic [stbuf_cfg_pkg::COUNT_W-1:0]   count;

   // ----------------------------------------
   // write stage lanes
   // ----------------------------------------
   always_comb begin
      case (store_size)
         stbuf_op_pkg::SIZE_BYTE: size_mask = stbuf_op_pkg::LANE_MASK_BYTE;
         stbuf_op_pkg::SIZE_HALF: size_mask = stbuf_op_pkg::LANE_MASK_HALF;
         stbuf_op_pkg::SIZE_WORD: size_mask = stbuf_op_pkg::LANE_MASK_WORD;
         default:                 size_mask = stbuf_op_pkg::LANE_MASK_DWORD;
      endcase
   end

   assign lane_ext     = size_mask << store_addr[stbuf_cfg_pkg::LANE_BITS-1:0];
   assign wr_byteen_lo = lane_ext[3:0];
   assign wr_byteen_hi = lane_ext[7:4];
   assign wr_dual      = |wr_byteen_hi;   // spills into the next word
   assign wr_vld       = store_vld;
   assign wr_word_lo   = store_addr[stbuf_cfg_pkg::ADDR_BITS-1:stbuf_cfg_pkg::LANE_BITS];
   assign wr_word_hi   = wr_word_lo + 1'b1;

   assign wr_ptr_p1  = wr_ptr + 1'b1;
   assign res_ptr_p1 = res_ptr[LAG-1] + 1'b1;
   assign pop        = (drain_req & drain_ack) | ent_flushed[rd_ptr];   // flushed head drops itself

   // ----------------------------------------
   // pointers and resolve pipeline
   // ----------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         res_ptr  <= '{default: '0};
         res_dual <= '{default: 1'b0};
      end else begin
         if (store_vld) begin
            wr_ptr <= wr_dual ? wr_ptr + stbuf_cfg_pkg::ptr_t'(2) : wr_ptr_p1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         res_ptr[0]  <= wr_ptr;
         res_dual[0] <= wr_dual;
         for (int s = 1; s < LAG; s++) begin
            res_ptr[s]  <= res_ptr[s-1];
            res_dual[s] <= res_dual[s-1];
         end
      end
   end

   // ----------------------------------------
   // entry state
   // ----------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ent_vld     <= '0;
         ent_drain   <= '0;
         ent_flushed <= '0;
      end else begin
         for (int i = 0; i < stbuf_cfg_pkg::DEPTH; i++) begin
            if (pop && stbuf_cfg_pkg::ptr_t'(i) == rd_ptr) begin
               ent_vld[i]     <= 1'b0;
               ent_drain[i]   <= 1'b0;
               ent_flushed[i] <= 1'b0;
            end else begin
               if (store_vld && (stbuf_cfg_pkg::ptr_t'(i) == wr_ptr ||
                                 (wr_dual && stbuf_cfg_pkg::ptr_t'(i) == wr_ptr_p1))) begin
                  ent_vld[i] <= 1'b1;
               end
               if (resolve_vld && (stbuf_cfg_pkg::ptr_t'(i) == res_ptr[LAG-1] ||
                                   (res_dual[LAG-1] && stbuf_cfg_pkg::ptr_t'(i) == res_ptr_p1))) begin
                  ent_drain[i]   <= resolve_commit;
                  ent_flushed[i] <= ~resolve_commit;
               end
            end
         end
      end
   end

   // payload, low word at wr_ptr and high word right after it
   always_ff @(posedge clk) begin
      for (int i = 0; i < stbuf_cfg_pkg::DEPTH; i++) begin
         if (store_vld && stbuf_cfg_pkg::ptr_t'(i) == wr_ptr) begin
            ent_word[i]   <= wr_word_lo;
            ent_byteen[i] <= wr_byteen_lo;
            ent_data[i]   <= store_data_lo;
         end else if (store_vld && wr_dual && stbuf_cfg_pkg::ptr_t'(i) == wr_ptr_p1) begin
            ent_word[i]   <= wr_word_hi;
            ent_byteen[i] <= wr_byteen_hi;
            ent_data[i]   <= store_data_hi;
         end
      end
   end

   // ----------------------------------------
   // drain port and status
   // ----------------------------------------
   assign drain_req    = ent_drain[rd_ptr];
   assign drain_addr   = {ent_word[rd_ptr], {stbuf_cfg_pkg::LANE_BITS{1'b0}}};
   assign drain_byteen = ent_byteen[rd_ptr];
   assign drain_data   = ent_data[rd_ptr];

   always_comb begin
      count = '0;
      for (int i = 0; i < stbuf_cfg_pkg::DEPTH; i++) begin
         count = count + stbuf_cfg_pkg::COUNT_W'(ent_vld[i]);
      end
   end

   // two slots kept spare for a dual write
   assign stbuf_full  = count > stbuf_cfg_pkg::COUNT_W'(stbuf_cfg_pkg::DEPTH - 2);
   assign stbuf_empty = count == '0;

endmodule

// File: rtl/stbuf_entry_fwd.sv
module stbuf_entry_fwd (
   input  stbuf_cfg_pkg::addr_t                                  load_addr,
   input  logic [stbuf_cfg_pkg::DEPTH-1:0]                       ent_vld,
   input  logic [stbuf_cfg_pkg::DEPTH-1:0]                       ent_flushed,
   input  stbuf_cfg_pkg::word_addr_t [stbuf_cfg_pkg::DEPTH-1:0] ent_word,
   input  stbuf_cfg_pkg::byteen_t [stbuf_cfg_pkg::DEPTH-1:0]    ent_byteen,
   input  stbuf_cfg_pkg::data_t [stbuf_cfg_pkg::DEPTH-1:0]      ent_data,
   input  stbuf_cfg_pkg::ptr_t                                   wr_ptr,
   output stbuf_cfg_pkg::byteen_t                                ebuf_byteen_lo,
   output stbuf_cfg_pkg::byteen_t                                ebuf_byteen_hi,
   output stbuf_cfg_pkg::data_t                                  ebuf_data_lo,
   output stbuf_cfg_pkg::data_t                                  ebuf_data_hi
);

   stbuf_cfg_pkg::word_addr_t       ld_word_lo;
   stbuf_cfg_pkg::word_addr_t       ld_word_hi;
   logic [stbuf_cfg_pkg::DEPTH-1:0] hit_lo;
   logic [stbuf_cfg_pkg::DEPTH-1:0] hit_hi;

   assign ld_word_lo = load_addr[stbuf_cfg_pkg::ADDR_BITS-1:stbuf_cfg_pkg::LANE_BITS];
   assign ld_word_hi = ld_word_lo + 1'b1;

   // word match per entry, age not yet considered
   always_comb begin
      for (int i = 0; i < stbuf_cfg_pkg::DEPTH; i++) begin
         hit_lo[i] = ent_vld[i] & ~ent_flushed[i] & (ent_word[i] == ld_word_lo);
         hit_hi[i] = ent_vld[i] & ~ent_flushed[i] & (ent_word[i] == ld_word_hi);
      end
   end

   // oldest slot sits at wr_ptr, so later iterations are younger and win
   always_comb begin : p_walk
      stbuf_cfg_pkg::ptr_t idx;
      ebuf_byteen_lo = '0;
      ebuf_byteen_hi = '0;
      ebuf_data_lo   = '0;
      ebuf_data_hi   = '0;
      for (int k = 0; k < stbuf_cfg_pkg::DEPTH; k++) begin
         idx = wr_ptr + stbuf_cfg_pkg::ptr_t'(k);
         for (int b = 0; b < stbuf_cfg_pkg::BYTE_WIDTH; b++) begin
            if (hit_lo[idx] && ent_byteen[idx][b]) begin
               ebuf_byteen_lo[b]      = 1'b1;
               ebuf_data_lo[8*b +: 8] = ent_data[idx][8*b +: 8];
            end
            if (hit_hi[idx] && ent_byteen[idx][b]) begin
               ebuf_byteen_hi[b]      = 1'b1;
               ebuf_data_hi[8*b +: 8] = ent_data[idx][8*b +: 8];
            end
         end
      end
   end

endmodule

// File: rtl/stbuf_jit_fwd.sv
module stbuf_jit_fwd (
   input  stbuf_cfg_pkg::addr_t      load_addr,
   input  logic                      wr_vld,
   input  logic                      wr_dual,
   input  stbuf_cfg_pkg::word_addr_t wr_word_lo,
   input  stbuf_cfg_pkg::word_addr_t wr_word_hi,
   input  stbuf_cfg_pkg::byteen_t    wr_byteen_lo,
   input  stbuf_cfg_pkg::byteen_t    wr_byteen_hi,
   input  stbuf_cfg_pkg::data_t      store_data_lo,
   input  stbuf_cfg_pkg::data_t      store_data_hi,
   output stbuf_cfg_pkg::byteen_t    jit_byteen_lo,
   output stbuf_cfg_pkg::byteen_t    jit_byteen_hi,
   output stbuf_cfg_pkg::data_t      jit_data_lo,
   output stbuf_cfg_pkg::data_t      jit_data_hi
);

   stbuf_cfg_pkg::word_addr_t ld_word_lo;
   stbuf_cfg_pkg::word_addr_t ld_word_hi;
   logic                      lo_from_lo;   // load lo word vs store lo word
   logic                      lo_from_hi;
   logic                      hi_from_lo;
   logic                      hi_from_hi;

   assign ld_word_lo = load_addr[stbuf_cfg_pkg::ADDR_BITS-1:stbuf_cfg_pkg::LANE_BITS];
   assign ld_word_hi = ld_word_lo + 1'b1;

   // store hi part only exists on a dual write
   assign lo_from_lo = wr_vld & (wr_word_lo == ld_word_lo);
   assign lo_from_hi = wr_vld & wr_dual & (wr_word_hi == ld_word_lo);
   assign hi_from_lo = wr_vld & (wr_word_lo == ld_word_hi);
   assign hi_from_hi = wr_vld & wr_dual & (wr_word_hi == ld_word_hi);

   assign jit_byteen_lo = ({stbuf_cfg_pkg::BYTE_WIDTH{lo_from_lo}} & wr_byteen_lo) |
                          ({stbuf_cfg_pkg::BYTE_WIDTH{lo_from_hi}} & wr_byteen_hi);
   assign jit_byteen_hi = ({stbuf_cfg_pkg::BYTE_WIDTH{hi_from_lo}} & wr_byteen_lo) |
                          ({stbuf_cfg_pkg::BYTE_WIDTH{hi_from_hi}} & wr_byteen_hi);

   // the two store words never hit the same load word, so one mux per lane
   always_comb begin
      for (int b = 0; b < stbuf_cfg_pkg::BYTE_WIDTH; b++) begin
         jit_data_lo[8*b +: 8] = {8{jit_byteen_lo[b]}} &
                                 (lo_from_hi ? store_data_hi[8*b +: 8] : store_data_lo[8*b +: 8]);
         jit_data_hi[8*b +: 8] = {8{jit_byteen_hi[b]}} &
                                 (hi_from_hi ? store_data_hi[8*b +: 8] : store_data_lo[8*b +: 8]);
      end
   end

endmodule

// File: rtl/stbuf_fwd_merge.sv
module stbuf_fwd_merge (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   load_vld,
   input  stbuf_cfg_pkg::byteen_t ebuf_byteen_lo,
   input  stbuf_cfg_pkg::byteen_t ebuf_byteen_hi,
   input  stbuf_cfg_pkg::data_t   ebuf_data_lo,
   input  stbuf_cfg_pkg::data_t   ebuf_data_hi,
   input  stbuf_cfg_pkg::byteen_t jit_byteen_lo,
   input  stbuf_cfg_pkg::byteen_t jit_byteen_hi,
   input  stbuf_cfg_pkg::data_t   jit_data_lo,
   input  stbuf_cfg_pkg::data_t   jit_data_hi,
   output stbuf_cfg_pkg::byteen_t fwd_byteen_lo,
   output stbuf_cfg_pkg::byteen_t fwd_byteen_hi,
   output stbuf_cfg_pkg::data_t   fwd_data_lo,
   output stbuf_cfg_pkg::data_t   fwd_data_hi
);

   stbuf_cfg_pkg::byteen_t byteen_lo_nxt;
   stbuf_cfg_pkg::byteen_t byteen_hi_nxt;
   stbuf_cfg_pkg::data_t   data_lo_nxt;
   stbuf_cfg_pkg::data_t   data_hi_nxt;

   // store in the write stage is younger than anything buffered
   function automatic stbuf_cfg_pkg::data_t pick_lanes(input stbuf_cfg_pkg::byteen_t jit_en,
                                                       input stbuf_cfg_pkg::data_t   jit_d,
                                                       input stbuf_cfg_pkg::data_t   ebuf_d);
      stbuf_cfg_pkg::data_t d;
      for (int b = 0; b < stbuf_cfg_pkg::BYTE_WIDTH; b++) begin
         d[8*b +: 8] = jit_en[b] ? jit_d[8*b +: 8] : ebuf_d[8*b +: 8];
      end
      return d;
   endfunction

   assign byteen_lo_nxt = (jit_byteen_lo | ebuf_byteen_lo) & {stbuf_cfg_pkg::BYTE_WIDTH{load_vld}};
   assign byteen_hi_nxt = (jit_byteen_hi | ebuf_byteen_hi) & {stbuf_cfg_pkg::BYTE_WIDTH{load_vld}};
   assign data_lo_nxt   = pick_lanes(jit_byteen_lo, jit_data_lo, ebuf_data_lo);
   assign data_hi_nxt   = pick_lanes(jit_byteen_hi, jit_data_hi, ebuf_data_hi);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fwd_byteen_lo <= '0;
         fwd_byteen_hi <= '0;
      end else begin
         fwd_byteen_lo <= byteen_lo_nxt;
         fwd_byteen_hi <= byteen_hi_nxt;
      end
   end

   always_ff @(posedge clk) begin
      fwd_data_lo <= load_vld ? data_lo_nxt : '0;
      fwd_data_hi <= load_vld ? data_hi_nxt : '0;
   end

endmodule

// File: rtl/stbuf_top.sv
module stbuf_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   store_vld,
   input  stbuf_cfg_pkg::addr_t   store_addr,
   input  stbuf_op_pkg::size_t    store_size,
   input  stbuf_cfg_pkg::data_t   store_data_lo,
   input  stbuf_cfg_pkg::data_t   store_data_hi,
   input  logic                   resolve_vld,
   input  logic                   resolve_commit,
   output logic                   drain_req,
   output stbuf_cfg_pkg::addr_t   drain_addr,
   output stbuf_cfg_pkg::byteen_t drain_byteen,
   output stbuf_cfg_pkg::data_t   drain_data,
   input  logic                   drain_ack,
   input  logic                   load_vld,
   input  stbuf_cfg_pkg::addr_t   load_addr,
   output stbuf_cfg_pkg::byteen_t fwd_byteen_lo,
   output stbuf_cfg_pkg::byteen_t fwd_byteen_hi,
   output stbuf_cfg_pkg::data_t   fwd_data_lo,
   output stbuf_cfg_pkg::data_t   fwd_data_hi,
   output logic                   stbuf_full,
   output logic                   stbuf_empty
);

   // entry arrays toward the search
   logic [stbuf_cfg_pkg::DEPTH-1:0]                       ent_vld;
   logic [stbuf_cfg_pkg::DEPTH-1:0]                       ent_flushed;
   stbuf_cfg_pkg::word_addr_t [stbuf_cfg_pkg::DEPTH-1:0] ent_word;
   stbuf_cfg_pkg::byteen_t [stbuf_cfg_pkg::DEPTH-1:0]    ent_byteen;
   stbuf_cfg_pkg::data_t [stbuf_cfg_pkg::DEPTH-1:0]      ent_data;
   stbuf_cfg_pkg::ptr_t                                   wr_ptr;

   // current write
   logic                      wr_vld;
   logic                      wr_dual;
   stbuf_cfg_pkg::word_addr_t wr_word_lo;
   stbuf_cfg_pkg::word_addr_t wr_word_hi;
   stbuf_cfg_pkg::byteen_t    wr_byteen_lo;
   stbuf_cfg_pkg::byteen_t    wr_byteen_hi;

   // partial forwarding results
   stbuf_cfg_pkg::byteen_t ebuf_byteen_lo;
   stbuf_cfg_pkg::byteen_t ebuf_byteen_hi;
   stbuf_cfg_pkg::data_t   ebuf_data_lo;
   stbuf_cfg_pkg::data_t   ebuf_data_hi;
   stbuf_cfg_pkg::byteen_t jit_byteen_lo;
   stbuf_cfg_pkg::byteen_t jit_byteen_hi;
   stbuf_cfg_pkg::data_t   jit_data_lo;
   stbuf_cfg_pkg::data_t   jit_data_hi;

   stbuf_entries stbuf_entries_inst (.*);

   stbuf_entry_fwd stbuf_entry_fwd_inst (.*);

   stbuf_jit_fwd stbuf_jit_fwd_inst (.*);

   stbuf_fwd_merge stbuf_fwd_merge_inst (.*);

endmodule

// File: tests/stbuf_sva.sv
module stbuf_sva (
   input logic                            clk,
   input logic                            rst_n,
   input logic                            store_vld,
   input logic                            stbuf_full,
   input logic                            stbuf_empty,
   input logic                            drain_req,
   input logic                            drain_ack,
   input logic [stbuf_cfg_pkg::DEPTH-1:0] ent_vld,
   input logic [stbuf_cfg_pkg::DEPTH-1:0] ent_drain,
   input logic [stbuf_cfg_pkg::DEPTH-1:0] ent_flushed
);
   timeunit 1ns;
   timeprecision 100ps;

   // environment holds stores back while full
   no_store_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      stbuf_full |-> !store_vld)
      else $error("store presented while the buffer was full");

   // resolve only marks entries that still hold their store
   marks_on_valid_entries: assert property (@(posedge clk) disable iff (!rst_n)
      ((ent_drain | ent_flushed) & ~ent_vld) == '0)
      else $error("commit or flush mark on an empty entry");

   ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      drain_ack |-> drain_req)
      else $error("drain_ack given without drain_req");

   empty_no_req: assert property (@(posedge clk) disable iff (!rst_n)
      stbuf_empty |-> !drain_req)
      else $error("drain_req high while the buffer is empty");

endmodule

bind stbuf_entries stbuf_sva stbuf_sva_inst (
   .clk         (clk),
   .rst_n       (rst_n),
   .store_vld   (store_vld),
   .stbuf_full  (stbuf_full),
   .stbuf_empty (stbuf_empty),
   .drain_req   (drain_req),
   .drain_ack   (drain_ack),
   .ent_vld     (ent_vld),
   .ent_drain   (ent_drain),
   .ent_flushed (ent_flushed)
);

// File: tests/stbuf_tb.sv
module stbuf_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          HALF_PERIOD = 4;
   localparam int          NS_PER_LINE = 200;   // watchdog budget per pattern line
   localparam logic [31:0] LFSR_SEED   = 32'hc3d1_9e88;
   localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1

   typedef struct packed {
      logic [7:0]  kind;
      logic [31:0] a0;
      logic [31:0] a1;
      logic [31:0] a2;
      logic [31:0] a3;
      logic [31:0] a4;
   } pattern_t;

   typedef struct packed {
      stbuf_cfg_pkg::addr_t   addr;
      stbuf_cfg_pkg::byteen_t byteen;
      stbuf_cfg_pkg::data_t   data;
   } beat_t;

   logic                   clk = 1'b0;
   logic                   rst_n;
   logic                   store_vld;
   stbuf_cfg_pkg::addr_t   store_addr;
   stbuf_op_pkg::size_t    store_size;
   stbuf_cfg_pkg::data_t   store_data_lo;
   stbuf_cfg_pkg::data_t   store_data_hi;
   logic                   resolve_vld;
   logic                   resolve_commit;
   logic                   drain_req;
   stbuf_cfg_pkg::addr_t   drain_addr;
   stbuf_cfg_pkg::byteen_t drain_byteen;
   stbuf_cfg_pkg::data_t   drain_data;
   logic                   drain_ack;
   logic                   load_vld;
   stbuf_cfg_pkg::addr_t   load_addr;
   stbuf_cfg_pkg::byteen_t fwd_byteen_lo;
   stbuf_cfg_pkg::byteen_t fwd_byteen_hi;
   stbuf_cfg_pkg::data_t   fwd_data_lo;
   stbuf_cfg_pkg::data_t   fwd_data_hi;
   logic                   stbuf_full;
   logic                   stbuf_empty;

   pattern_t               patterns[$];
   beat_t                  exp_drain[$];   // committed words in store order
   logic                   loaded = 1'b0;
   logic [1:0]             res_vld_q;      // resolve delay line
   logic [1:0]             res_commit_q;
   logic                   ack_mode;
   logic [31:0]            lfsr;
   logic                   fwd_pending;
   stbuf_cfg_pkg::byteen_t exp_be_lo;
   stbuf_cfg_pkg::byteen_t exp_be_hi;
   stbuf_cfg_pkg::data_t   exp_lo;
   stbuf_cfg_pkg::data_t   exp_hi;

   stbuf_top stbuf_top_inst (.*);

   always #HALF_PERIOD clk = ~clk;

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // lanes over two words, before the address shift
   function automatic logic [7:0] size_lanes(input logic [1:0] size);
      case (size)
         2'd0:    return 8'h01;
         2'd1:    return 8'h03;
         2'd2:    return 8'h0f;
         default: return 8'hff;
      endcase
   endfunction

   function automatic stbuf_cfg_pkg::data_t lane_bits(input stbuf_cfg_pkg::byteen_t be);
      stbuf_cfg_pkg::data_t m;
      for (int b = 0; b < stbuf_cfg_pkg::BYTE_WIDTH; b++) begin
         m[8*b +: 8] = {8{be[b]}};
      end
      return m;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   // ----------------------------------------
   // compare tasks
   // ----------------------------------------
   task automatic check_drain(input stbuf_cfg_pkg::addr_t   got_addr,
                              input stbuf_cfg_pkg::byteen_t got_be,
                              input stbuf_cfg_pkg::data_t   got_data,
                              input stbuf_cfg_pkg::addr_t   want_addr,
                              input stbuf_cfg_pkg::byteen_t want_be,
                              input stbuf_cfg_pkg::data_t   want_data);
      if (got_addr !== want_addr || got_be !== want_be || got_data !== want_data) begin
         stop_on_error($sformatf("error %0t ns: drain %h %h %h, expected %h %h %h", $time,
                                 got_addr, got_be, got_data, want_addr, want_be, want_data));
      end
   endtask

   task automatic check_fwd(input stbuf_cfg_pkg::byteen_t got_be_lo,
                            input stbuf_cfg_pkg::byteen_t got_be_hi,
                            input stbuf_cfg_pkg::data_t   got_lo,
                            input stbuf_cfg_pkg::data_t   got_hi,
                            input stbuf_cfg_pkg::byteen_t want_be_lo,
                            input stbuf_cfg_pkg::byteen_t want_be_hi,
                            input stbuf_cfg_pkg::data_t   want_lo,
                            input stbuf_cfg_pkg::data_t   want_hi);
      stbuf_cfg_pkg::data_t m_lo;
      stbuf_cfg_pkg::data_t m_hi;
      m_lo = lane_bits(want_be_lo);   // only forwarded lanes carry data
      m_hi = lane_bits(want_be_hi);
      if (got_be_lo !== want_be_lo || got_be_hi !== want_be_hi ||
          (got_lo & m_lo) !== (want_lo & m_lo) || (got_hi & m_hi) !== (want_hi & m_hi)) begin
         stop_on_error($sformatf("error %0t ns: forward %h %h %h %h, expected %h %h %h %h",
                                 $time, got_be_lo, got_be_hi, got_lo, got_hi,
                                 want_be_lo, want_be_hi, want_lo, want_hi));
      end
   endtask

   task automatic check_status(input logic got_full, input logic got_empty,
                               input logic want_full, input logic want_empty);
      if (got_full !== want_full || got_empty !== want_empty) begin
         stop_on_error($sformatf("error %0t ns: full %b empty %b, expected full %b empty %b",
                                 $time, got_full, got_empty, want_full, want_empty));
      end
   endtask

   // ----------------------------------------
   // cycle stepping and patterns
   // ----------------------------------------
   task automatic next_cycle();
      logic take;
      @(negedge clk);
      if (fwd_pending) begin
         check_fwd(fwd_byteen_lo, fwd_byteen_hi, fwd_data_lo, fwd_data_hi,
                   exp_be_lo, exp_be_hi, exp_lo, exp_hi);
      end
      fwd_pending    = 1'b0;
      store_vld      = 1'b0;
      load_vld       = 1'b0;
      resolve_vld    = res_vld_q[1];
      resolve_commit = res_commit_q[1];
      res_vld_q      = {res_vld_q[0], 1'b0};
      res_commit_q   = {res_commit_q[0], 1'b0};
      drain_ack      = 1'b0;
      if (ack_mode && drain_req) begin
         take = lfsr[0];
         lfsr = lfsr_next(lfsr);
         if (take && exp_drain.size() == 0) begin
            stop_on_error("drain request seen with no committed store left to drain");
         end else if (take) begin
            check_drain(drain_addr, drain_byteen, drain_data,
                        exp_drain[0].addr, exp_drain[0].byteen, exp_drain[0].data);
            void'(exp_drain.pop_front());
            drain_ack = 1'b1;
         end
      end
   endtask

   task automatic read_patterns();
      int       fd;
      int       got;
      string    kind;
      string    rest;
      pattern_t p;
      fd = $fopen("tests/stbuf_patterns.txt", "r");
      if (fd == 0) begin
         stop_on_error("cannot open tests/stbuf_patterns.txt");
      end else begin
         while ($fscanf(fd, "%s", kind) == 1) begin
            p      = '0;
            p.kind = kind.getc(0);
            case (p.kind)
               "S":     got = $fscanf(fd, "%h %d %h %h %d", p.a0, p.a1, p.a2, p.a3, p.a4) == 5;
               "L":     got = $fscanf(fd, "%h %h %h %h %h", p.a0, p.a1, p.a2, p.a3, p.a4) == 5;
               "I":     got = $fscanf(fd, "%d %d %d", p.a0, p.a1, p.a2) == 3;
               "D":     got = $fscanf(fd, "%d", p.a0) == 1;
               default: got = $fgets(rest, fd) > 0;   // comment line
            endcase
            if (!got) begin
               stop_on_error($sformatf("pattern line %c has missing fields", p.kind));
            end else if (p.kind != "#") begin
               patterns.push_back(p);
            end
         end
         $fclose(fd);
         loaded = 1'b1;
      end
   endtask

   task automatic run_pattern(input pattern_t p);
      logic [7:0]                lanes;
      stbuf_cfg_pkg::word_addr_t waddr;
      case (p.kind)
         "S": begin
            if (stbuf_full) begin
               stop_on_error("pattern file stores into a full buffer");
            end else begin
               store_vld       = 1'b1;
               store_addr      = p.a0[15:0];
               store_size      = stbuf_op_pkg::size_t'(p.a1[1:0]);
               store_data_lo   = p.a2;
               store_data_hi   = p.a3;
               res_vld_q[0]    = 1'b1;
               res_commit_q[0] = p.a4[0];
               lanes = size_lanes(p.a1[1:0]) << p.a0[1:0];
               waddr = p.a0[15:2];
               if (p.a4[0]) begin
                  exp_drain.push_back('{{waddr, 2'b00}, lanes[3:0], p.a2});
                  if (lanes[7:4] != 4'h0) begin   // spill into the next word
                     exp_drain.push_back('{{waddr + 1'b1, 2'b00}, lanes[7:4], p.a3});
                  end
               end
            end
         end
         "L": begin
            load_vld    = 1'b1;
            load_addr   = p.a0[15:0];
            fwd_pending = 1'b1;
            exp_be_lo   = p.a1[3:0];
            exp_be_hi   = p.a2[3:0];
            exp_lo      = p.a3;
            exp_hi      = p.a4;
         end
         "I": begin
            repeat (p.a0) next_cycle();
            check_status(stbuf_full, stbuf_empty, p.a1[0], p.a2[0]);
         end
         "D": ack_mode = p.a0[0];
         default: stop_on_error($sformatf("unknown pattern command %c", p.kind));
      endcase
   endtask

   // ----------------------------------------
   // main sequence and watchdog
   // ----------------------------------------
   initial begin : stimulus
      rst_n          = 1'b0;
      store_vld      = 1'b0;
      store_addr     = '0;
      store_size     = stbuf_op_pkg::SIZE_BYTE;
      store_data_lo  = '0;
      store_data_hi  = '0;
      resolve_vld    = 1'b0;
      resolve_commit = 1'b0;
      drain_ack      = 1'b0;
      load_vld       = 1'b0;
      load_addr      = '0;
      res_vld_q      = '0;
      res_commit_q   = '0;
      ack_mode       = 1'b0;
      fwd_pending    = 1'b0;
      lfsr           = LFSR_SEED;
      read_patterns();
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_status(stbuf_full, stbuf_empty, 1'b0, 1'b1);
      check_fwd(fwd_byteen_lo, fwd_byteen_hi, fwd_data_lo, fwd_data_hi, '0, '0, '0, '0);
      if (drain_req !== 1'b0) begin
         stop_on_error("drain_req is high straight after reset");
      end
      foreach (patterns[i]) begin
         run_pattern(patterns[i]);
      end
      if (exp_drain.size() != 0) begin
         stop_on_error($sformatf("%0d committed words never reached the drain port",
                                 exp_drain.size()));
      end else begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

   initial begin : watchdog
      wait (loaded);
      #(patterns.size() * NS_PER_LINE);
      stop_on_error($sformatf("watchdog expired at %0t ns, the run did not finish", $time));
   end

endmodule

// File: stbuf_top.f
rtl/stbuf_cfg_pkg.sv
rtl/stbuf_op_pkg.sv
rtl/stbuf_entries.sv
rtl/stbuf_entry_fwd.sv
rtl/stbuf_jit_fwd.sv
rtl/stbuf_fwd_merge.sv
rtl/stbuf_top.sv
tests/stbuf_sva.sv
tests/stbuf_tb.sv

// File: tests/stbuf_patterns.txt
# S addr size data_lo data_hi commit | L addr be_lo be_hi data_lo data_hi (hex)
# I cycles full empty, staged S and L go out in its first cycle | D 0 hold, D 1 random acks
S 0010 2 44332211 00000000 1
I 1 0 0
S 0013 1 bb000000 000000aa 1
I 1 0 0
S 0020 2 deadbeef 00000000 0
I 1 0 0
L 0020 f 0 deadbeef 00000000
I 1 0 0
L 0010 f 1 bb332211 000000aa
I 4 0 0
L 0020 0 0 00000000 00000000
I 1 0 0
S 0012 1 cccc0000 00000000 1
L 0010 f 1 cccc2211 000000aa
I 1 0 0
S 0017 1 ee000000 000000dd 1
L 0014 9 1 ee0000aa 000000dd
I 2 1 0
D 1
I 60 0 1
L 0010 0 0 00000000 00000000
I 1 0 1
